//--- hw/ro_pkg.sv
package ro_pkg;

   // line geometry
   localparam int WORDS_PER_LINE = 16;
   localparam int LINE_BITS      = 512;

   // read ids and threads
   localparam int LOG_N_IDS      = 5;
   localparam int LOG_N_THREADS  = 3;

   localparam int RDATA_FIFO_DEPTH = 4; // response buffer entries

   typedef logic [LOG_N_IDS-1:0]     id_t;
   typedef logic [LOG_N_THREADS-1:0] thread_t;

   typedef logic [3:0] word_idx_t;   // word position inside a line
   typedef logic [6:0] req_len_t;    // 1..64 words
   typedef logic [5:0] word_id_t;    // word index within a request

   // one entry per outstanding burst
   typedef struct packed {
      thread_t                   thread;
      logic [WORDS_PER_LINE-1:0] valid_words;
      word_id_t                  start_word_id;
   } mshr_entry_t;

endpackage

//--- hw/mshr_if.sv
`timescale 1ns/10ps

interface mshr_if;

   // burst write and thread count init, from the request side
   logic                wr_en;
   ro_pkg::id_t         wr_id;
   ro_pkg::mshr_entry_t wr_entry;
   logic                init_en;
   ro_pkg::thread_t     init_thread;
   ro_pkg::req_len_t    init_len;

   // lookup and countdown, from the response side
   ro_pkg::id_t         rd_id;
   ro_pkg::mshr_entry_t rd_entry;
   logic                dec_en;
   ro_pkg::thread_t     dec_thread;
   ro_pkg::req_len_t    remaining;

   modport writer (output wr_en, wr_id, wr_entry, init_en, init_thread, init_len);

   modport reader (output rd_id, dec_en, dec_thread, input rd_entry, remaining);

   modport tbl (input wr_en, wr_id, wr_entry, init_en, init_thread, init_len,
                input rd_id, dec_en, dec_thread,
                output rd_entry, remaining);

endinterface

//--- hw/free_list.sv
`timescale 1ns/10ps

module free_list #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 push,
   input  logic [LOG_DEPTH-1:0] push_data,
   input  logic                 pop,
   output logic [LOG_DEPTH-1:0] head,
   output logic                 empty,
   output logic                 full
);

   logic [LOG_DEPTH-1:0] mem [2**LOG_DEPTH];
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH:0]   count;
   logic                 loading;   // writing 0..N-1 after reset

   always_ff @(posedge clk) begin
      if (loading) begin
         mem[wr_ptr] <= wr_ptr;
      end else if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         loading <= 1'b1;
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
      end else if (loading) begin
         wr_ptr <= wr_ptr + 1'b1;
         count  <= count + 1'b1;
         if (wr_ptr == '1) loading <= 1'b0;   // wr_ptr wraps back to 0
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         if (push & !pop) begin
            count <= count + 1'b1;
         end else if (pop & !push) begin
            count <= count - 1'b1;
         end
      end
   end

   assign head  = mem[rd_ptr];
   assign empty = loading | (count == '0);
   assign full  = count[LOG_DEPTH];   // every index is back

endmodule

//--- hw/read_splitter.sv
`timescale 1ns/10ps

module read_splitter (
   input  logic             clk,
   input  logic             rstn,

   input  logic             req_valid,
   output logic             req_ready,
   input  logic [31:0]      req_addr,
   input  ro_pkg::req_len_t req_len,
   output ro_pkg::thread_t  req_thread,

   input  ro_pkg::thread_t  thread_head,
   input  logic             thread_empty,
   output logic             thread_pop,

   input  ro_pkg::id_t      id_head,
   input  logic             id_empty,
   output logic             id_pop,

   output logic             arvalid,
   input  logic             arready,
   output logic [31:0]      araddr,
   output ro_pkg::id_t      arid,

   mshr_if.writer           mshr
);

   logic             busy;          // a burst is pending
   logic [31:0]      cur_addr;
   ro_pkg::req_len_t words_left;
   ro_pkg::word_id_t start_word;
   ro_pkg::thread_t  cur_thread;

   ro_pkg::word_idx_t                 off;
   logic [4:0]                        line_room;
   ro_pkg::req_len_t                  burst_words;
   logic                              last_burst;
   logic [ro_pkg::WORDS_PER_LINE-1:0] burst_mask;
   logic                              ar_xfer;
   logic                              accept;

   assign off       = cur_addr[5:2];
   assign line_room = 5'd16 - {1'b0, off};   // words up to the line end
   assign last_burst = words_left <= ro_pkg::req_len_t'(line_room);
   assign burst_words = last_burst ? words_left : ro_pkg::req_len_t'(line_room);

   always_comb begin
      for (int i = 0; i < ro_pkg::WORDS_PER_LINE; i++) begin
         burst_mask[i] = (i >= int'(off)) && (i < int'(off) + int'(burst_words));
      end
   end

   assign arvalid = busy & !id_empty;
   assign araddr  = cur_addr;
   assign arid    = id_head;
   assign ar_xfer = arvalid & arready;
   assign id_pop  = ar_xfer;

   // a new request may overlap the final burst of the previous one
   assign req_ready  = !thread_empty & (!busy | (ar_xfer & last_burst));
   assign accept     = req_valid & req_ready;
   assign thread_pop = accept;
   assign req_thread = thread_head;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (accept) begin
         busy <= 1'b1;
      end else if (ar_xfer & last_burst) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_addr   <= req_addr;
         words_left <= req_len;
         start_word <= '0;
         cur_thread <= thread_head;
      end else if (ar_xfer) begin
         cur_addr   <= {cur_addr[31:6] + 26'd1, 6'd0};   // next line
         words_left <= words_left - burst_words;
         start_word <= start_word + ro_pkg::word_id_t'(burst_words);
      end
   end

   assign mshr.wr_en                  = ar_xfer;
   assign mshr.wr_id                  = id_head;
   assign mshr.wr_entry.thread        = cur_thread;
   assign mshr.wr_entry.valid_words   = burst_mask;
   assign mshr.wr_entry.start_word_id = start_word;

   assign mshr.init_en     = accept;
   assign mshr.init_thread = thread_head;
   assign mshr.init_len    = req_len;

endmodule

//--- hw/mshr_table.sv
`timescale 1ns/10ps

module mshr_table (
   input logic clk,
   input logic rstn,
   mshr_if.tbl mshr
);

   localparam int N_IDS     = 2**ro_pkg::LOG_N_IDS;
   localparam int N_THREADS = 2**ro_pkg::LOG_N_THREADS;

   ro_pkg::mshr_entry_t entries   [N_IDS];
   ro_pkg::req_len_t    remaining [N_THREADS];

   always_ff @(posedge clk) begin
      if (mshr.wr_en) begin
         entries[mshr.wr_id] <= mshr.wr_entry;
      end
   end

   assign mshr.rd_entry = entries[mshr.rd_id];

   // words still owed to each thread
   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int t = 0; t < N_THREADS; t++) begin
            remaining[t] <= '0;
         end
      end else begin
         for (int t = 0; t < N_THREADS; t++) begin
            if (mshr.init_en && (mshr.init_thread == ro_pkg::thread_t'(t))) begin
               remaining[t] <= mshr.init_len;
            end else if (mshr.dec_en && (mshr.dec_thread == ro_pkg::thread_t'(t))) begin
               remaining[t] <= remaining[t] - 1'b1;
            end
         end
      end
   end

   // a thread is only reissued after its last word, so init and dec never meet

   assign mshr.remaining = remaining[mshr.dec_thread];

endmodule

//--- hw/resp_unpacker.sv
`timescale 1ns/10ps

module resp_unpacker (
   input  logic                         clk,
   input  logic                         rstn,

   input  logic                         rvalid,
   output logic                         rready,
   input  ro_pkg::id_t                  rid,
   input  logic [ro_pkg::LINE_BITS-1:0] rdata,

   output logic                         out_valid,
   input  logic                         out_ready,
   output logic [31:0]                  out_data,
   output ro_pkg::thread_t              out_thread,
   output ro_pkg::word_id_t             out_word_id,
   output logic                         out_last,

   output logic                         id_push,
   output ro_pkg::id_t                  id_push_data,
   output logic                         thread_push,
   output ro_pkg::thread_t              thread_push_data,

   mshr_if.reader                       mshr
);

   logic [ro_pkg::LINE_BITS-1:0] buf_data [ro_pkg::RDATA_FIFO_DEPTH];
   ro_pkg::id_t                  buf_rid  [ro_pkg::RDATA_FIFO_DEPTH];
   logic [$clog2(ro_pkg::RDATA_FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(ro_pkg::RDATA_FIFO_DEPTH)-1:0] rd_ptr;
   logic [$clog2(ro_pkg::RDATA_FIFO_DEPTH):0]   buf_count;
   logic buf_wr;
   logic load;

   logic                              cur_valid;
   logic [ro_pkg::LINE_BITS-1:0]      cur_data;
   logic [ro_pkg::WORDS_PER_LINE-1:0] cur_mask;
   logic [ro_pkg::WORDS_PER_LINE-1:0] next_mask;
   ro_pkg::thread_t                   cur_thread;
   ro_pkg::word_id_t                  cur_word_id;
   ro_pkg::word_idx_t                 low_idx;
   logic                              fire;

   assign rready = buf_count != ro_pkg::RDATA_FIFO_DEPTH;
   assign buf_wr = rvalid & rready;

   always_ff @(posedge clk) begin
      if (buf_wr) begin
         buf_data[wr_ptr] <= rdata;
         buf_rid[wr_ptr]  <= rid;
      end
   end

   // lowest pending word of the current line
   always_comb begin
      low_idx = '0;
      for (int i = ro_pkg::WORDS_PER_LINE - 1; i >= 0; i--) begin
         if (cur_mask[i]) low_idx = ro_pkg::word_idx_t'(i);
      end
   end

   assign next_mask = cur_mask & ~(16'b1 << low_idx);
   assign fire      = out_valid & out_ready;
   assign load      = (buf_count != '0) & (!cur_valid | (fire & (next_mask == '0)));

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         buf_count <= '0;
         cur_valid <= 1'b0;
      end else begin
         if (buf_wr) wr_ptr <= wr_ptr + 1'b1;
         if (load)   rd_ptr <= rd_ptr + 1'b1;
         if (buf_wr & !load) begin
            buf_count <= buf_count + 1'b1;
         end else if (load & !buf_wr) begin
            buf_count <= buf_count - 1'b1;
         end
         if (load) begin
            cur_valid <= 1'b1;
         end else if (fire & (next_mask == '0)) begin
            cur_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         cur_data    <= buf_data[rd_ptr];
         cur_mask    <= mshr.rd_entry.valid_words;
         cur_thread  <= mshr.rd_entry.thread;
         cur_word_id <= mshr.rd_entry.start_word_id;
      end else if (fire) begin
         cur_mask    <= next_mask;
         cur_word_id <= cur_word_id + 1'b1;   // burst words are contiguous
      end
   end

   assign mshr.rd_id = buf_rid[rd_ptr];
   assign id_push      = load;   // entry copied, id can be reused
   assign id_push_data = buf_rid[rd_ptr];

   assign out_valid   = cur_valid;
   assign out_data    = cur_data[low_idx*32 +: 32];
   assign out_thread  = cur_thread;
   assign out_word_id = cur_word_id;
   assign out_last    = cur_valid & (mshr.remaining == ro_pkg::req_len_t'(1));

   assign mshr.dec_en     = fire;
   assign mshr.dec_thread = cur_thread;

   assign thread_push      = fire & out_last;
   assign thread_push_data = cur_thread;

endmodule

//--- hw/read_only_stage.sv
`timescale 1ns/10ps

module read_only_stage (
   input  logic                         clk,
   input  logic                         rstn,

   input  logic                         req_valid,
   output logic                         req_ready,
   input  logic [31:0]                  req_addr,
   input  ro_pkg::req_len_t             req_len,
   output ro_pkg::thread_t              req_thread,

   output logic                         arvalid,
   input  logic                         arready,
   output logic [31:0]                  araddr,
   output ro_pkg::id_t                  arid,

   input  logic                         rvalid,
   output logic                         rready,
   input  ro_pkg::id_t                  rid,
   input  logic [ro_pkg::LINE_BITS-1:0] rdata,

   output logic                         out_valid,
   input  logic                         out_ready,
   output logic [31:0]                  out_data,
   output ro_pkg::thread_t              out_thread,
   output ro_pkg::word_id_t             out_word_id,
   output logic                         out_last,

   output logic                         idle   // every thread is free
);

   ro_pkg::thread_t thread_head;
   logic            thread_empty;
   logic            thread_pop;
   logic            thread_push;
   ro_pkg::thread_t thread_push_data;

   ro_pkg::id_t     id_head;
   logic            id_empty;
   logic            id_pop;
   logic            id_push;
   ro_pkg::id_t     id_push_data;

   mshr_if mshr ();

   free_list #(.LOG_DEPTH(ro_pkg::LOG_N_THREADS)) thread_list (
      .clk       (clk),
      .rstn      (rstn),
      .push      (thread_push),
      .push_data (thread_push_data),
      .pop       (thread_pop),
      .head      (thread_head),
      .empty     (thread_empty),
      .full      (idle)
   );

   free_list #(.LOG_DEPTH(ro_pkg::LOG_N_IDS)) id_list (
      .clk       (clk),
      .rstn      (rstn),
      .push      (id_push),
      .push_data (id_push_data),
      .pop       (id_pop),
      .head      (id_head),
      .empty     (id_empty),
      .full      ()
   );

   read_splitter splitter (
      .clk          (clk),
      .rstn         (rstn),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req_addr     (req_addr),
      .req_len      (req_len),
      .req_thread   (req_thread),
      .thread_head  (thread_head),
      .thread_empty (thread_empty),
      .thread_pop   (thread_pop),
      .id_head      (id_head),
      .id_empty     (id_empty),
      .id_pop       (id_pop),
      .arvalid      (arvalid),
      .arready      (arready),
      .araddr       (araddr),
      .arid         (arid),
      .mshr         (mshr.writer)
   );

   mshr_table table_i (
      .clk  (clk),
      .rstn (rstn),
      .mshr (mshr.tbl)
   );

   resp_unpacker unpacker (
      .clk              (clk),
      .rstn             (rstn),
      .rvalid           (rvalid),
      .rready           (rready),
      .rid              (rid),
      .rdata            (rdata),
      .out_valid        (out_valid),
      .out_ready        (out_ready),
      .out_data         (out_data),
      .out_thread       (out_thread),
      .out_word_id      (out_word_id),
      .out_last         (out_last),
      .id_push          (id_push),
      .id_push_data     (id_push_data),
      .thread_push      (thread_push),
      .thread_push_data (thread_push_data),
      .mshr             (mshr.reader)
   );

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model (
   input  logic        clk,
   input  logic        rstn,
   input  logic [31:0] rnd,
   input  logic        arvalid,
   output logic        arready,
   input  logic [31:0] araddr,
   input  ro_pkg::id_t arid,
   output logic        rvalid,
   input  logic        rready,
   output ro_pkg::id_t rid,
   output logic [31:0] rline_addr   // line whose words sit on rdata
);

   logic [31:0] pend_addr [$];
   ro_pkg::id_t pend_id   [$];
   int          pend_due  [$];
   int          cycle;
   int          n_due;
   int          pick;
   int          sel;
   logic        sent;

   initial begin
      arready    = 1'b0;
      rvalid     = 1'b0;
      rid        = '0;
      rline_addr = '0;
      cycle      = 0;
   end

   always @(posedge clk) begin
      sent = rvalid & rready;
      if (rstn && arvalid && arready) begin
         pend_addr.push_back({araddr[31:6], 6'd0});
         pend_id.push_back(arid);
         pend_due.push_back(cycle + 1 + int'(rnd[4:0]));   // random latency
      end
      cycle++;
      #1;
      arready = rstn & (rnd[10:8] != 3'd0);
      if (sent || !rstn) rvalid = 1'b0;
      if (rstn && !rvalid) begin
         n_due = 0;
         for (int i = 0; i < pend_due.size(); i++) begin
            if (pend_due[i] <= cycle) n_due++;
         end
         if (n_due > 0) begin
            // any due read may go first, so lines return out of order
            pick = int'(rnd[23:16]) % n_due;
            sel  = -1;
            for (int i = 0; i < pend_due.size(); i++) begin
               if (pend_due[i] <= cycle) begin
                  if (pick == 0 && sel < 0) sel = i;
                  pick--;
               end
            end
            rvalid     = 1'b1;
            rid        = pend_id[sel];
            rline_addr = pend_addr[sel];
            pend_addr.delete(sel);
            pend_id.delete(sel);
            pend_due.delete(sel);
         end
      end
   end

endmodule

//--- testbench/tb_read_only_stage.sv
`timescale 1ns/10ps

module tb_read_only_stage;

   localparam logic [31:0] SEED = 32'h6eeb4887;
   localparam int N_REQ = 40;   // two directed, the rest random
   localparam int WATCHDOG_CYCLES = N_REQ * 64 * 20;

   logic                         clk;
   logic                         rstn;
   logic                         req_valid;
   logic                         req_ready;
   logic [31:0]                  req_addr;
   ro_pkg::req_len_t             req_len;
   ro_pkg::thread_t              req_thread;
   logic                         arvalid;
   logic                         arready;
   logic [31:0]                  araddr;
   ro_pkg::id_t                  arid;
   logic                         rvalid;
   logic                         rready;
   ro_pkg::id_t                  rid;
   logic [ro_pkg::LINE_BITS-1:0] rdata;
   logic [31:0]                  rline_addr;
   logic                         out_valid;
   logic                         out_ready;
   logic [31:0]                  out_data;
   ro_pkg::thread_t              out_thread;
   ro_pkg::word_id_t             out_word_id;
   logic                         out_last;
   logic                         idle;

   logic [31:0] stim_rand;
   logic [31:0] mem_rand;
   logic        stall_on;
   logic        stall_now;

   // open request per thread
   logic [31:0] rec_addr [8];
   int          rec_len  [8];
   int          rec_got  [8];
   logic [63:0] rec_seen [8];
   logic        rec_busy [8];
   int          accepted;
   int          last_count;

   logic             held;   // beat was stalled on the last edge
   logic [31:0]      held_data;
   ro_pkg::thread_t  held_thread;
   ro_pkg::word_id_t held_word_id;

   function automatic logic [31:0] next_rand(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // memory contents, a hash of the byte address
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      return next_rand(next_rand(addr ^ 32'h5bd1e995));
   endfunction

   function automatic logic [31:0] expected_word(input logic [31:0] base, input int word_id);
      return mem_word(base + 32'(4 * word_id));
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h",
                             $time, name, got, exp));
      end
   endtask

   task automatic send_request(input logic [31:0] addr, input int len);
      req_addr  = addr;
      req_len   = ro_pkg::req_len_t'(len);
      req_valid = 1'b1;
      do @(posedge clk); while (!req_ready);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_idle();
      do @(posedge clk); while (!idle);
      #1;
   endtask

   initial clk = 1'b0;
   always #4 clk = ~clk;

   always @(posedge clk) mem_rand <= next_rand(mem_rand);

   always @(posedge clk) begin
      stall_now = stall_on;
      #1;
      out_ready = stall_now ? (mem_rand[29:27] > 3'd2) : 1'b1;   // about 3 in 8 stalled
   end

   always_comb begin
      for (int w = 0; w < ro_pkg::WORDS_PER_LINE; w++) begin
         rdata[w*32 +: 32] = mem_word(rline_addr + 32'(4 * w));
      end
   end

   read_only_stage dut (
      .clk         (clk),
      .rstn        (rstn),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req_addr    (req_addr),
      .req_len     (req_len),
      .req_thread  (req_thread),
      .arvalid     (arvalid),
      .arready     (arready),
      .araddr      (araddr),
      .arid        (arid),
      .rvalid      (rvalid),
      .rready      (rready),
      .rid         (rid),
      .rdata       (rdata),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out_data    (out_data),
      .out_thread  (out_thread),
      .out_word_id (out_word_id),
      .out_last    (out_last),
      .idle        (idle)
   );

   tb_mem_model mem (
      .clk        (clk),
      .rstn       (rstn),
      .rnd        (mem_rand),
      .arvalid    (arvalid),
      .arready    (arready),
      .araddr     (araddr),
      .arid       (arid),
      .rvalid     (rvalid),
      .rready     (rready),
      .rid        (rid),
      .rline_addr (rline_addr)
   );

   // scoreboard
   always @(posedge clk) begin
      int   t;
      int   id;
      logic any_open;
      if (rstn) begin
         any_open = 1'b0;
         for (int i = 0; i < 8; i++) begin
            any_open = any_open | rec_busy[i];
         end
         // thread list has loaded by the first request
         if (accepted > 0) check_value("idle", idle, !any_open);

         if (held) begin
            check_value("out_valid while stalled", out_valid, 1);
            check_value("out_data while stalled", out_data, held_data);
            check_value("out_thread while stalled", out_thread, held_thread);
            check_value("out_word_id while stalled", out_word_id, held_word_id);
         end
         held         = out_valid & !out_ready;
         held_data    = out_data;
         held_thread  = out_thread;
         held_word_id = out_word_id;

         if (out_valid && out_ready) begin
            t  = int'(out_thread);
            id = int'(out_word_id);
            if (!rec_busy[t]) abort_run($sformatf("beat for thread %0d with no open request", t));
            if (id >= rec_len[t]) begin
               abort_run($sformatf("thread %0d got word %0d past its length", t, id));
            end
            if (rec_seen[t][id]) abort_run($sformatf("thread %0d got word %0d twice", t, id));
            rec_seen[t][id] = 1'b1;
            rec_got[t]++;
            check_value("out_data", out_data, expected_word(rec_addr[t], id));
            check_value("out_last", out_last, rec_got[t] == rec_len[t]);
            if (out_last) begin
               rec_busy[t] = 1'b0;
               last_count++;
            end
         end

         if (req_valid && req_ready) begin
            t = int'(req_thread);
            if (rec_busy[t]) abort_run($sformatf("thread %0d handed out before its last word", t));
            rec_addr[t] = req_addr;
            rec_len[t]  = int'(req_len);
            rec_got[t]  = 0;
            rec_seen[t] = '0;
            rec_busy[t] = 1'b1;
            accepted++;
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      abort_run($sformatf("timeout, requests not done after %0d cycles", WATCHDOG_CYCLES));
   end

   initial begin
      logic [31:0] addr;
      int          len;
      rstn       = 1'b0;
      req_valid  = 1'b0;
      req_addr   = '0;
      req_len    = 7'd1;
      out_ready  = 1'b0;
      stall_on   = 1'b0;
      stim_rand  = SEED;
      mem_rand   = ~SEED;
      accepted   = 0;
      last_count = 0;
      held       = 1'b0;
      for (int t = 0; t < 8; t++) begin
         rec_busy[t] = 1'b0;
      end
      repeat (3) @(posedge clk);
      #1;
      rstn = 1'b1;

      send_request(32'h0000_1000, 1);   // single aligned word
      wait_idle();
      send_request(32'h0000_2000 + 32'(13 * 4), 40);   // spans four lines
      wait_idle();

      stall_on = 1'b1;
      for (int n = 2; n < N_REQ; n++) begin
         stim_rand = next_rand(stim_rand);
         addr      = 32'h0001_0000 + {14'd0, stim_rand[17:2], 2'b00};
         len       = int'(stim_rand[25:20]) + 1;
         send_request(addr, len);
         wait_cycles(int'(stim_rand[29:28]));
      end
      wait_idle();

      if (last_count == accepted && accepted == N_REQ) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         check_value("out_last count", last_count, accepted);
         check_value("accepted requests", accepted, N_REQ);
      end
   end

endmodule

//--- read_only_stage.f
hw/ro_pkg.sv
hw/mshr_if.sv
hw/free_list.sv
hw/read_splitter.sv
hw/mshr_table.sv
hw/resp_unpacker.sv
hw/read_only_stage.sv
testbench/tb_mem_model.sv
testbench/tb_read_only_stage.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the read_only_stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   -f read_only_stage.f \
   --top-module tb_read_only_stage \
   -o sim_read_only_stage

./obj_dir/sim_read_only_stage
